// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - logic/cpu_bus_pkg.sv
      - logic/cpu_isa_pkg.sv
      - logic/cpu_alu.sv
      - logic/cpu_decode.sv
      - logic/cpu_datapath.sv
      - logic/cpu_sequencer.sv
      - logic/cpu_core.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/cpu_core_asserts.sv
      - tb/cpu_core_tb.sv

// File: cpu_core.f
logic/cpu_bus_pkg.sv
logic/cpu_isa_pkg.sv
logic/cpu_alu.sv
logic/cpu_decode.sv
logic/cpu_datapath.sv
logic/cpu_sequencer.sv
logic/cpu_core.sv
tb/tb_clock.sv
tb/cpu_core_asserts.sv
tb/cpu_core_tb.sv

// File: logic/cpu_alu.sv
// Binary arithmetic only, no decimal mode; co after subtract is the inverted borrow
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  cpu_isa_pkg::alu_op_e op,
    input  cpu_bus_pkg::data_t   a,
    input  cpu_bus_pkg::data_t   b,
    input  logic                 ci,
    output cpu_bus_pkg::data_t   result,
    output logic                 co
);

    cpu_bus_pkg::data_t b_add;                      // b or its complement
    logic [8:0]         sum;                        // Carry in bit 8

    assign b_add = (op == cpu_isa_pkg::ALU_SUB) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_add} + {8'd0, ci};

    always_comb begin
        co = ci;                                    // Logic ops keep the carry
        case (op)
            cpu_isa_pkg::ALU_ADD,
            cpu_isa_pkg::ALU_SUB: begin
                result = sum[7:0];
                co     = sum[8];
            end
            cpu_isa_pkg::ALU_AND: result = a & b;
            cpu_isa_pkg::ALU_OR:  result = a | b;
            cpu_isa_pkg::ALU_EOR: result = a ^ b;
            default:              result = a;       // Pass-through
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu_bus_pkg.sv
// Memory bus types; widths are fixed by the 6502 map and zero page is always page 00
`default_nettype none

package cpu_bus_pkg;

    typedef logic [15:0] addr_t;                    // Memory address
    typedef logic [7:0]  data_t;                    // Data byte

    localparam data_t ZERO_PAGE    = 8'h00;         // High byte of zero-page accesses
    localparam addr_t RESET_VECTOR = 16'hFFFC;      // Start address low byte, high at +1

endpackage

`default_nettype wire

// File: logic/cpu_core.sv
// Teaching subset of a 6502 core; no interrupts, stack, branches, Y register or decimal mode
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic               clk,
    input  logic               reset,
    output cpu_bus_pkg::addr_t ab,
    input  cpu_bus_pkg::data_t di,
    output cpu_bus_pkg::data_t do_bus,
    output logic               we,
    input  logic               rdy
);

    cpu_isa_pkg::ctrl_t ctrl;
    logic               decode_now;
    logic               alu_en;
    logic               wb_en;
    cpu_bus_pkg::data_t operand;                    // Opcode in DECODE, data later
    cpu_bus_pkg::data_t reg_out;

    cpu_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .rdy        (rdy),
        .di         (di),
        .ctrl       (ctrl),
        .reg_out    (reg_out),
        .ab         (ab),
        .do_bus     (do_bus),
        .we         (we),
        .decode_now (decode_now),
        .alu_en     (alu_en),
        .wb_en      (wb_en),
        .operand    (operand)
    );

    cpu_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .rdy        (rdy),
        .decode_now (decode_now),
        .opcode     (operand),
        .ctrl       (ctrl)
    );

    cpu_datapath u_datapath (
        .clk     (clk),
        .reset   (reset),
        .rdy     (rdy),
        .ctrl    (ctrl),
        .alu_en  (alu_en),
        .wb_en   (wb_en),
        .operand (operand),
        .reg_out (reg_out),
        .alu_out ()                                 // Result used inside datapath only
    );

endmodule

`default_nettype wire

// File: logic/cpu_datapath.sv
// Only A, X and C exist; results are written back in the FETCH cycle and only while rdy is high
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
    input  logic               clk,
    input  logic               reset,
    input  logic               rdy,
    input  cpu_isa_pkg::ctrl_t ctrl,
    input  logic               alu_en,
    input  logic               wb_en,
    input  cpu_bus_pkg::data_t operand,
    output cpu_bus_pkg::data_t reg_out,
    output cpu_bus_pkg::data_t alu_out
);

    cpu_bus_pkg::data_t   a_reg;                    // Accumulator
    cpu_bus_pkg::data_t   x_reg;
    logic                 c_flag;
    cpu_bus_pkg::data_t   alu_a;
    cpu_bus_pkg::data_t   alu_b;
    logic                 alu_ci;
    logic                 alu_co;
    cpu_isa_pkg::alu_op_e alu_op;

    assign reg_out = (ctrl.src == cpu_isa_pkg::SEL_X) ? x_reg : a_reg;

    assign alu_a  = ctrl.load_only ? '0 : reg_out;  // Loads add operand to zero
    assign alu_b  = (ctrl.mode == cpu_isa_pkg::MODE_IMPLIED) ? '0 : operand;
    assign alu_op = alu_en ? ctrl.alu_op : cpu_isa_pkg::ALU_PASS;

    always_comb begin
        if (ctrl.carry_in_one) begin
            alu_ci = 1'b1;                          // CMP and INX
        end else if (ctrl.use_carry) begin
            alu_ci = c_flag;                        // ADC and SBC
        end else begin
            alu_ci = 1'b0;
        end
    end

    cpu_alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .ci     (alu_ci),
        .result (alu_out),
        .co     (alu_co)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_reg  <= '0;
            x_reg  <= '0;
            c_flag <= 1'b0;
        end else if (wb_en && rdy) begin
            if (ctrl.load_reg) begin
                if (ctrl.dst == cpu_isa_pkg::SEL_X) begin
                    x_reg <= alu_out;
                end else begin
                    a_reg <= alu_out;
                end
            end
            if (ctrl.upd_c) begin
                c_flag <= alu_co;                   // ADC, SBC, CMP
            end else if (ctrl.set_c) begin
                c_flag <= 1'b1;
            end else if (ctrl.clr_c) begin
                c_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_decode.sv
// Decode of the kept subset only; ctrl follows the opcode combinationally while decode_now is high
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               rdy,
    input  logic               decode_now,
    input  cpu_bus_pkg::data_t opcode,
    output cpu_isa_pkg::ctrl_t ctrl
);

    localparam cpu_isa_pkg::ctrl_t CTRL_NOP = '{
        mode:    cpu_isa_pkg::MODE_IMPLIED,
        alu_op:  cpu_isa_pkg::ALU_PASS,
        src:     cpu_isa_pkg::SEL_A,
        dst:     cpu_isa_pkg::SEL_A,
        default: 1'b0
    };

    cpu_isa_pkg::ctrl_t dec;                        // Decode of the opcode on the bus
    cpu_isa_pkg::ctrl_t ctrl_q;                     // Held for the rest of the instruction

    always_comb begin
        dec = CTRL_NOP;                             // Unknown opcodes write nothing
        casez (opcode)
            cpu_isa_pkg::OP_NOP, cpu_isa_pkg::OP_STA_IMM: begin
                dec = CTRL_NOP;
            end
            8'b???0_1001, 8'b???0_0101: begin       // Group one, imm and zp columns
                dec.mode     = opcode[2] ? cpu_isa_pkg::MODE_ZP : cpu_isa_pkg::MODE_IMM;
                dec.load_reg = 1'b1;
                case (opcode[7:5])
                    3'b000: dec.alu_op = cpu_isa_pkg::ALU_OR;
                    3'b001: dec.alu_op = cpu_isa_pkg::ALU_AND;
                    3'b010: dec.alu_op = cpu_isa_pkg::ALU_EOR;
                    3'b011: begin                   // ADC
                        dec.alu_op    = cpu_isa_pkg::ALU_ADD;
                        dec.use_carry = 1'b1;
                        dec.upd_c     = 1'b1;
                    end
                    3'b100: begin                   // STA
                        dec.load_reg = 1'b0;
                        dec.store    = 1'b1;
                    end
                    3'b101: begin                   // LDA
                        dec.alu_op    = cpu_isa_pkg::ALU_ADD;
                        dec.load_only = 1'b1;
                    end
                    3'b110: begin                   // CMP, flags only
                        dec.alu_op       = cpu_isa_pkg::ALU_SUB;
                        dec.load_reg     = 1'b0;
                        dec.carry_in_one = 1'b1;
                        dec.upd_c        = 1'b1;
                    end
                    default: begin                  // SBC
                        dec.alu_op    = cpu_isa_pkg::ALU_SUB;
                        dec.use_carry = 1'b1;
                        dec.upd_c     = 1'b1;
                    end
                endcase
            end
            cpu_isa_pkg::OP_LDX_IMM, cpu_isa_pkg::OP_LDX_ZP: begin
                dec.mode      = opcode[2] ? cpu_isa_pkg::MODE_ZP : cpu_isa_pkg::MODE_IMM;
                dec.alu_op    = cpu_isa_pkg::ALU_ADD;
                dec.dst       = cpu_isa_pkg::SEL_X;
                dec.load_reg  = 1'b1;
                dec.load_only = 1'b1;
            end
            cpu_isa_pkg::OP_STX_ZP: begin
                dec.mode  = cpu_isa_pkg::MODE_ZP;
                dec.src   = cpu_isa_pkg::SEL_X;
                dec.store = 1'b1;
            end
            cpu_isa_pkg::OP_INX: begin              // X + 0 + 1
                dec.alu_op       = cpu_isa_pkg::ALU_ADD;
                dec.src          = cpu_isa_pkg::SEL_X;
                dec.dst          = cpu_isa_pkg::SEL_X;
                dec.load_reg     = 1'b1;
                dec.carry_in_one = 1'b1;
            end
            cpu_isa_pkg::OP_TAX: begin
                dec.alu_op   = cpu_isa_pkg::ALU_ADD;
                dec.dst      = cpu_isa_pkg::SEL_X;
                dec.load_reg = 1'b1;
            end
            cpu_isa_pkg::OP_TXA: begin
                dec.alu_op   = cpu_isa_pkg::ALU_ADD;
                dec.src      = cpu_isa_pkg::SEL_X;
                dec.load_reg = 1'b1;
            end
            cpu_isa_pkg::OP_CLC:     dec.clr_c = 1'b1;
            cpu_isa_pkg::OP_SEC:     dec.set_c = 1'b1;
            cpu_isa_pkg::OP_JMP_ABS: dec.mode  = cpu_isa_pkg::MODE_JMP;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_q <= CTRL_NOP;
        end else if (decode_now && rdy) begin
            ctrl_q <= dec;
        end
    end

    // Sequencer needs the mode while the opcode is still on the bus
    assign ctrl = decode_now ? dec : ctrl_q;

endmodule

`default_nettype wire

// File: logic/cpu_isa_pkg.sv
// Instruction subset definitions; opcodes use standard 6502 encodings, all others act as NOP
`default_nettype none

package cpu_isa_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,                                    // a + b + ci
        ALU_SUB,                                    // a + ~b + ci
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_PASS                                    // Result is a, carry untouched
    } alu_op_e;

    typedef enum logic {
        SEL_A,
        SEL_X
    } reg_sel_e;

    typedef enum logic [1:0] {
        MODE_IMPLIED,                               // No operand byte
        MODE_IMM,                                   // Operand follows opcode
        MODE_ZP,                                    // Operand is a zero-page address
        MODE_JMP                                    // Two address bytes follow
    } mode_e;

    // Opcodes that do not fit the group-one ALU pattern
    localparam cpu_bus_pkg::data_t OP_LDX_IMM = 8'hA2;
    localparam cpu_bus_pkg::data_t OP_LDX_ZP  = 8'hA6;
    localparam cpu_bus_pkg::data_t OP_STX_ZP  = 8'h86;
    localparam cpu_bus_pkg::data_t OP_STA_IMM = 8'h89;  // Hole in group one
    localparam cpu_bus_pkg::data_t OP_INX     = 8'hE8;
    localparam cpu_bus_pkg::data_t OP_TAX     = 8'hAA;
    localparam cpu_bus_pkg::data_t OP_TXA     = 8'h8A;
    localparam cpu_bus_pkg::data_t OP_CLC     = 8'h18;
    localparam cpu_bus_pkg::data_t OP_SEC     = 8'h38;
    localparam cpu_bus_pkg::data_t OP_NOP     = 8'hEA;
    localparam cpu_bus_pkg::data_t OP_JMP_ABS = 8'h4C;

    typedef struct packed {
        mode_e    mode;                             // Addressing path
        alu_op_e  alu_op;
        reg_sel_e src;                              // ALU a input and store source
        reg_sel_e dst;                              // Register written back
        logic     load_reg;                         // Writes dst
        logic     store;                            // Writes memory
        logic     load_only;                        // ALU a forced to zero
        logic     use_carry;                        // ci = C
        logic     carry_in_one;                     // ci = 1, compare and INX
        logic     set_c;                            // SEC
        logic     clr_c;                            // CLC
        logic     upd_c;                            // C takes carry out
    } ctrl_t;

endpackage

`default_nettype wire

// File: logic/cpu_sequencer.sv
// Memory must return read data in the cycle after the address; ab, we and do_bus hold while rdy is low
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               rdy,
    input  cpu_bus_pkg::data_t di,
    input  cpu_isa_pkg::ctrl_t ctrl,
    input  cpu_bus_pkg::data_t reg_out,
    output cpu_bus_pkg::addr_t ab,
    output cpu_bus_pkg::data_t do_bus,
    output logic               we,
    output logic               decode_now,
    output logic               alu_en,
    output logic               wb_en,
    output cpu_bus_pkg::data_t operand
);

    typedef enum logic [2:0] {
        VEC0,                                       // Address low vector byte
        VEC1,                                       // Address high vector byte
        DECODE,                                     // Opcode on bus, read next byte
        FETCH,                                      // Fetch next opcode, write back
        ZP0,                                        // Zero-page read or write
        JMP0,                                       // Read high target byte
        JMP1                                        // Target on ab
    } state_e;

    state_e             state;
    state_e             state_nxt;
    cpu_bus_pkg::addr_t pc;
    cpu_bus_pkg::addr_t pc_nxt;
    cpu_bus_pkg::data_t adl;                        // Held low address byte
    cpu_bus_pkg::data_t di_hold;                    // di from first cycle of the state
    logic               rdy_q;                      // Low if last cycle stalled

    // Data arrives in the first cycle of a state, hold it through the stall
    assign operand = rdy_q ? di : di_hold;

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        ab        = pc;
        case (state)
            VEC0: begin
                ab        = cpu_bus_pkg::RESET_VECTOR;
                state_nxt = VEC1;
            end
            VEC1: begin
                ab        = cpu_bus_pkg::RESET_VECTOR + 16'd1;
                state_nxt = JMP1;                   // Vector loads like a jump
            end
            DECODE: begin
                case (ctrl.mode)
                    cpu_isa_pkg::MODE_ZP:  state_nxt = ZP0;
                    cpu_isa_pkg::MODE_JMP: state_nxt = JMP0;
                    default:               state_nxt = FETCH;
                endcase
                if (ctrl.mode != cpu_isa_pkg::MODE_IMPLIED) begin
                    pc_nxt = pc + 16'd1;            // Consume operand byte
                end
            end
            FETCH: begin
                pc_nxt    = pc + 16'd1;
                state_nxt = DECODE;
            end
            ZP0: begin
                ab        = {cpu_bus_pkg::ZERO_PAGE, operand};
                state_nxt = FETCH;
            end
            JMP0: begin
                state_nxt = JMP1;
            end
            JMP1: begin
                ab        = {operand, adl};
                pc_nxt    = {operand, adl} + 16'd1;
                state_nxt = DECODE;
            end
            default: state_nxt = VEC0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= VEC0;
            pc    <= '0;
            rdy_q <= 1'b1;
        end else begin
            rdy_q <= rdy;
            if (rdy) begin
                state <= state_nxt;
                pc    <= pc_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        di_hold <= operand;
        if (rdy && (state == VEC1 || state == JMP0)) begin
            adl <= operand;                         // Low byte of vector or target
        end
    end

    assign we         = (state == ZP0) && ctrl.store;
    assign do_bus     = reg_out;
    assign decode_now = (state == DECODE);
    assign alu_en     = (state == FETCH);
    assign wb_en      = alu_en && !ctrl.store;      // Stores only touch memory

endmodule

`default_nettype wire

// File: tb/cpu_core_asserts.sv
// Bound into cpu_core; properties sample at the rising edge and are off while reset is high
`timescale 1ns/1ps
`default_nettype none

module cpu_core_asserts (
    input logic               clk,
    input logic               reset,
    input logic               rdy,
    input cpu_bus_pkg::addr_t ab,
    input cpu_bus_pkg::data_t do_bus,
    input logic               we
);

    logic [2:0] bus_cycles;                         // rdy cycles since reset, saturates
    int         failures = 0;                       // Read by the testbench

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_cycles <= '0;
        end else if (rdy && bus_cycles != 3'd7) begin
            bus_cycles <= bus_cycles + 3'd1;
        end
    end

    // Two vector reads, target fetch and decode come before the earliest ZP0 store
    no_early_write: assert property (@(posedge clk) (reset || bus_cycles < 3'd4) |-> !we)
        else begin
            $error("we went high before the first store could execute");
            failures++;
        end

    stall_holds_bus: assert property (@(posedge clk) disable iff (reset)
        !rdy |=> ($stable(ab) && $stable(we) && $stable(do_bus)))
        else begin
            $error("ab, we or do_bus changed during a rdy stall");
            failures++;
        end

    write_in_zero_page: assert property (@(posedge clk) disable iff (reset)
        we |-> (ab[15:8] == 8'h00))
        else begin
            $error("write outside the zero page");
            failures++;
        end

endmodule

`default_nettype wire

// File: tb/cpu_core_tb.sv
// One seeded random program at 0200 over a fill pattern; writes are checked in order against a model
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

    typedef struct packed {
        cpu_bus_pkg::addr_t addr;
        cpu_bus_pkg::data_t data;
    } bus_write_t;

    localparam int                 NUM_INSTR = 200;
    localparam int                 LIMIT     = NUM_INSTR * 3 * 2 + 50;  // Slowest mix, half stalled
    localparam cpu_bus_pkg::addr_t START     = 16'h0200;
    // LDA LDX ADC SBC AND ORA EOR CMP, immediate then zero page
    localparam logic [127:0] ALU_OPS = {8'hA9, 8'hA5, 8'hA2, 8'hA6, 8'h69, 8'h65, 8'hE9, 8'hE5,
                                        8'h29, 8'h25, 8'h09, 8'h05, 8'h49, 8'h45, 8'hC9, 8'hC5};
    // INX TAX TXA CLC SEC NOP
    localparam logic [47:0]  IMP_OPS = {8'hE8, 8'hAA, 8'h8A, 8'h18, 8'h38, 8'hEA};

    logic               clk;
    logic               reset;
    cpu_bus_pkg::addr_t ab;
    cpu_bus_pkg::data_t di;
    cpu_bus_pkg::data_t do_bus;
    logic               we;
    logic               rdy;

    cpu_bus_pkg::data_t mem [0:65535];              // Memory seen by the DUT
    cpu_bus_pkg::data_t ref_mem [0:65535];          // Memory of the model
    bit                 skipped [0:65535];          // Bytes that a forward jump passes over
    bus_write_t         expected [$];               // Predicted writes in order
    cpu_bus_pkg::addr_t rd_addr = '0;               // Address taken at the last rdy edge
    cpu_bus_pkg::addr_t end_addr;                   // Final JMP to itself
    integer             seed = 68;
    int                 bus_cycles = 0;             // Edges with rdy high
    int                 writes = 0;
    int                 stalls = 0;
    int                 jumps = 0;                  // Jumps taken by the model
    int                 vector_fails = 0;
    int                 trace_fails = 0;
    int                 count_fails = 0;
    int                 jump_fails = 0;
    int                 passed = 0;
    int                 failed = 0;
    int                 cycles;
    logic               done = 1'b0;                // Final JMP reached on the bus

    tb_clock u_clock (
        .clk (clk)
    );

    cpu_core UUT (
        .clk    (clk),
        .reset  (reset),
        .ab     (ab),
        .di     (di),
        .do_bus (do_bus),
        .we     (we),
        .rdy    (rdy)
    );

    bind cpu_core cpu_core_asserts u_asserts (
        .clk    (clk),
        .reset  (reset),
        .rdy    (rdy),
        .ab     (ab),
        .do_bus (do_bus),
        .we     (we)
    );

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic cpu_bus_pkg::data_t random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val, inout int fails);
        if (exp_val !== act_val) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_val, act_val);
            fails++;
        end
    endtask

    task automatic report_test(input string name, input int fails);
        if (fails == 0) begin
            $display("PASS  %s", name);
            passed++;
        end else begin
            $display("FAIL  %s (%0d errors)", name, fails);
            failed++;
        end
    endtask

    task automatic record_expected_write(input cpu_bus_pkg::addr_t addr,
                                         input cpu_bus_pkg::data_t data);
        bus_write_t w;
        ref_mem[addr] = data;
        w.addr        = addr;
        w.data        = data;
        expected.push_back(w);
    endtask

    task automatic land_jump(input cpu_bus_pkg::addr_t patch,
                             input cpu_bus_pkg::addr_t target);
        int k;
        mem[patch]         = target[7:0];
        mem[patch + 16'd1] = target[15:8];
        for (k = int'(patch) + 2; k < int'(target); k++) begin
            skipped[k] = 1'b1;                      // Never on ab if the jump is taken
        end
    endtask

    task automatic build_program();
        cpu_bus_pkg::addr_t pc;
        cpu_bus_pkg::addr_t patch;                  // JMP operand awaiting its target
        int                 skip;
        int                 pick;
        int                 i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;      // Fill from the whole address
        end
        mem[16'hFFFC] = START[7:0];
        mem[16'hFFFD] = START[15:8];
        pc    = START;
        patch = '0;
        skip  = 0;
        for (i = 0; i < NUM_INSTR; i++) begin
            if (skip > 0) begin
                skip--;
                if (skip == 0) begin                // Pending JMP lands here
                    land_jump(patch, pc);
                end
            end
            pick = random_below(20);
            if (pick < 4) begin
                mem[pc]         = (pick < 2) ? 8'h85 : 8'h86;   // STA or STX zp
                mem[pc + 16'd1] = random_byte();
                pc              = pc + 16'd2;
            end else if (pick == 4 && skip == 0) begin
                mem[pc] = 8'h4C;                    // Forward JMP abs
                patch   = pc + 16'd1;
                skip    = 2 + random_below(3);      // Jumps over one to three
                pc      = pc + 16'd3;
            end else if (pick < 13) begin
                pick            = random_below(16);
                mem[pc]         = ALU_OPS[8 * pick +: 8];
                mem[pc + 16'd1] = random_byte();
                pc              = pc + 16'd2;
            end else begin
                pick    = random_below(6);
                mem[pc] = IMP_OPS[8 * pick +: 8];
                pc      = pc + 16'd1;
            end
        end
        if (skip > 0) begin                         // Late JMP lands on the final loop
            land_jump(patch, pc);
        end
        end_addr        = pc;
        mem[pc]         = 8'h4C;
        mem[pc + 16'd1] = pc[7:0];
        mem[pc + 16'd2] = pc[15:8];
        for (i = 0; i < 65536; i++) begin
            ref_mem[i] = mem[i];
        end
    endtask

    task automatic run_model();
        cpu_bus_pkg::addr_t pc;
        cpu_bus_pkg::addr_t target;
        cpu_bus_pkg::data_t a;
        cpu_bus_pkg::data_t x;
        cpu_bus_pkg::data_t opc;
        cpu_bus_pkg::data_t arg;
        cpu_bus_pkg::data_t val;
        logic               c;
        logic [8:0]         sum;
        logic               stop;
        int                 len;
        int                 steps;
        pc    = START;
        a     = '0;
        x     = '0;
        c     = 1'b0;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 4 * NUM_INSTR) begin
            opc = ref_mem[pc];
            arg = ref_mem[pc + 16'd1];
            val = opc[2] ? ref_mem[{8'h00, arg}] : arg;         // Zero page or immediate
            len = 2;
            steps++;
            case (opc)
                8'h4C: begin                        // JMP abs
                    target = {ref_mem[pc + 16'd2], arg};
                    stop   = (target == pc);
                    if (!stop) begin
                        jumps++;
                    end
                    pc  = target;
                    len = 0;
                end
                8'hA9, 8'hA5: a = val;              // LDA
                8'hA2, 8'hA6: x = val;              // LDX
                8'h69, 8'h65: begin                 // ADC
                    sum = {1'b0, a} + {1'b0, val} + {8'h00, c};
                    a   = sum[7:0];
                    c   = sum[8];
                end
                8'hE9, 8'hE5: begin                 // SBC, borrow is !C
                    sum = {1'b0, a} - {1'b0, val} - {8'h00, !c};
                    a   = sum[7:0];
                    c   = !sum[8];
                end
                8'h29, 8'h25: a = a & val;
                8'h09, 8'h05: a = a | val;
                8'h49, 8'h45: a = a ^ val;
                8'hC9, 8'hC5: c = (a >= val);       // CMP leaves A alone
                8'h85: record_expected_write({8'h00, arg}, a);
                8'h86: record_expected_write({8'h00, arg}, x);
                default: begin                      // One-byte opcodes
                    len = 1;
                    case (opc)
                        8'hE8:   x = x + 8'd1;
                        8'hAA:   x = a;
                        8'h8A:   a = x;
                        8'h18:   c = 1'b0;
                        8'h38:   c = 1'b1;
                        default: ;                  // NOP and unused opcodes
                    endcase
                end
            endcase
            pc = pc + len[15:0];
        end
    endtask

    // Synchronous memory and write monitor, active only on rdy edges
    always @(posedge clk) begin
        if (!reset && !rdy) begin
            stalls++;
        end
        if (!reset && rdy) begin
            if (we) begin
                if (writes < expected.size()) begin
                    check_value("ab", expected[writes].addr, ab, trace_fails);
                    check_value("do_bus", expected[writes].data, do_bus, trace_fails);
                end else begin
                    $display("Write to %h is past the end of the predicted write list", ab);
                    trace_fails++;
                end
                mem[ab] = do_bus;
                writes++;
            end
            if (skipped[ab]) begin
                $display("Address %h was read inside a block that a jump passes over", ab);
                jump_fails++;
            end
            if (bus_cycles == 2) begin              // After FFFC and FFFD
                check_value("first opcode ab", START, ab, vector_fails);
            end
            if (ab == end_addr + 16'd2) begin       // High byte of the final JMP
                done = 1'b1;
            end
            rd_addr = ab;
            bus_cycles++;
        end
    end

    always @(negedge clk) begin
        if (rdy) begin
            di <= mem[rd_addr];                     // Data one cycle after the address
        end else begin
            di <= random_byte();                    // Read data is gone after a stalled edge
        end
        rdy <= (random_below(4) != 0);              // About one stall in four
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: final jump not reached within %0d cycles", LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int stall_fails;
        stall_fails = 0;
        reset       = 1'b1;
        rdy         = 1'b1;
        di          = '0;
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!done) begin
            @(posedge clk);
        end
        check_value("write count", expected.size(), writes, count_fails);
        if (jumps == 0) begin
            $display("The program took no jump inside its body");
            jump_fails++;
        end
        if (stalls == 0) begin
            $display("No rdy stall cycles happened during the run");
            stall_fails++;
        end
        report_test("reset vector fetch", vector_fails);
        report_test("write trace", trace_fails);
        report_test("write count", count_fails);
        report_test("jump continuation", jump_fails + trace_fails);
        report_test("rdy stalls", stall_fails + trace_fails + count_fails);
        report_test("bus assertions", UUT.u_asserts.failures);
        $display("Tests: %0d passed, %0d failed; %0d writes, %0d stall cycles",
                 passed, failed, writes, stalls);
        if (failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Free-running clock that starts low; the period is fixed at 100 ns
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 50ns;             // 100 ns period

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire
